// File: Makefile
# Verilator build and run of the RAS testbench.
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_ras \
		-f ras.f --Mdir $(OBJ_DIR) -o Vtb_ras

run: compile
	./$(OBJ_DIR)/Vtb_ras | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/ras_pkg.sv
package ras_pkg;

    // Stack geometry.
    localparam int RAS_SIZE = 16;
    localparam int RAS_WIDTH = $clog2(RAS_SIZE);

    // Fetch addressing.
    localparam int VADDR_W = 32;
    localparam int OFFSET_W = 4;      // Slot offset in half words.
    localparam int INST_OFFSET = 1;   // Half word to byte shift.

    // Bit 1 writes an entry, bit 0 pops one.
    typedef enum logic [1:0] {
        NONE     = 2'd0,
        POP      = 2'd1,
        PUSH     = 2'd2,
        POP_PUSH = 2'd3
    } ras_op_e;

    typedef logic [RAS_WIDTH-1:0] ptr_t;   // Stack index.

    typedef logic [VADDR_W-1:0] vaddr_t;   // Virtual address.

endpackage

// File: design/ras_ptr_ctrl.sv
`timescale 1ns/1ps

module ras_ptr_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             request,
    input  ras_pkg::ras_op_e op,
    input  logic             squash,
    input  ras_pkg::ras_op_e squash_op,
    input  ras_pkg::ptr_t    ckpt_top_in,
    input  ras_pkg::ptr_t    ckpt_bottom_in,
    input  logic             ckpt_tdir_in,
    input  logic             ckpt_bdir_in,
    output ras_pkg::ptr_t    top,
    output ras_pkg::ptr_t    bottom,
    output logic             tdir,
    output logic             bdir,
    output logic             empty,
    output logic             full,
    output logic             ckpt_empty,
    output logic             ckpt_full
);
    import ras_pkg::*;

    logic    act;
    ras_op_e sel_op;
    ptr_t    src_top;
    ptr_t    src_bottom;
    logic    src_tdir;
    logic    src_bdir;
    logic    src_empty;
    logic    src_full;
    ptr_t    top_inc;
    ptr_t    top_dec;
    ptr_t    bottom_inc;
    logic    top_at_last;
    logic    top_at_first;
    logic    bottom_at_last;
    logic    do_push;
    logic    do_pop;

    // Live state flags.
    assign empty = (top == bottom) & (tdir == bdir);
    assign full  = (top == bottom) & (tdir != bdir);

    // Flags of the restored checkpoint.
    assign ckpt_empty = (ckpt_top_in == ckpt_bottom_in) & (ckpt_tdir_in == ckpt_bdir_in);
    assign ckpt_full  = (ckpt_top_in == ckpt_bottom_in) & (ckpt_tdir_in != ckpt_bdir_in);

    // Squash wins over a request in the same cycle.
    assign act    = squash | request;
    assign sel_op = squash ? squash_op : op;

    // A squash replays its op on top of the checkpoint instead of the live state.
    assign src_top    = squash ? ckpt_top_in : top;
    assign src_bottom = squash ? ckpt_bottom_in : bottom;
    assign src_tdir   = squash ? ckpt_tdir_in : tdir;
    assign src_bdir   = squash ? ckpt_bdir_in : bdir;
    assign src_empty  = squash ? ckpt_empty : empty;
    assign src_full   = squash ? ckpt_full : full;

    assign top_inc    = src_top + 1'b1;
    assign top_dec    = src_top - 1'b1;
    assign bottom_inc = src_bottom + 1'b1;

    assign top_at_last    = &src_top;
    assign top_at_first   = ~|src_top;
    assign bottom_at_last = &src_bottom;

    // POP_PUSH on an empty stack has nothing to replace, so it pushes.
    assign do_push = (sel_op == PUSH) | ((sel_op == POP_PUSH) & src_empty);
    assign do_pop  = (sel_op == POP) & ~src_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            top    <= '0;
            bottom <= '0;
            tdir   <= 1'b0;
            bdir   <= 1'b0;
        end else if (act) begin
            top    <= src_top;   // Restore, or hold for a plain request.
            bottom <= src_bottom;
            tdir   <= src_tdir;
            bdir   <= src_bdir;
            if (do_push) begin
                top  <= top_inc;
                tdir <= src_tdir ^ top_at_last;
                // Overflow drops the oldest entry.
                if (src_full) begin
                    bottom <= bottom_inc;
                    bdir   <= src_bdir ^ bottom_at_last;
                end
            end else if (do_pop) begin
                top  <= top_dec;
                tdir <= src_tdir ^ top_at_first;
            end
        end
    end

endmodule

// File: design/ras_stack_mem.sv
`timescale 1ns/1ps

module ras_stack_mem (
    input  logic            clk,
    input  logic            we,
    input  ras_pkg::ptr_t   waddr,
    input  ras_pkg::vaddr_t wdata,
    input  ras_pkg::ptr_t   raddr,
    output ras_pkg::vaddr_t rdata
);
    import ras_pkg::*;

    vaddr_t entries [RAS_SIZE];

    always_ff @(posedge clk) begin
        if (we) begin
            entries[waddr] <= wdata;
        end
    end

    // Zero latency read.
    assign rdata = entries[raddr];

endmodule

// File: design/ras_top.sv
`timescale 1ns/1ps

module ras_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         request,
    input  ras_pkg::ras_op_e             op,
    input  ras_pkg::vaddr_t              target,
    input  logic                         squash,
    input  ras_pkg::ras_op_e             squash_op,
    input  ras_pkg::vaddr_t              squash_start_addr,
    input  logic [ras_pkg::OFFSET_W-1:0] squash_offset,
    input  logic                         squash_rvc,
    input  ras_pkg::ptr_t                ckpt_top_in,
    input  ras_pkg::ptr_t                ckpt_bottom_in,
    input  logic                         ckpt_tdir_in,
    input  logic                         ckpt_bdir_in,
    output ras_pkg::vaddr_t              ret_addr,
    output logic                         valid,
    output ras_pkg::ptr_t                ckpt_top,
    output ras_pkg::ptr_t                ckpt_bottom,
    output logic                         ckpt_tdir,
    output logic                         ckpt_bdir
);
    import ras_pkg::*;

    ptr_t   top;
    ptr_t   bottom;
    logic   tdir;
    logic   bdir;
    logic   empty;
    logic   ckpt_empty;
    logic   we;
    ptr_t   waddr;
    vaddr_t wdata;
    ptr_t   raddr;
    vaddr_t rdata;

    ras_ptr_ctrl ras_ptr_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .request        (request),
        .op             (op),
        .squash         (squash),
        .squash_op      (squash_op),
        .ckpt_top_in    (ckpt_top_in),
        .ckpt_bottom_in (ckpt_bottom_in),
        .ckpt_tdir_in   (ckpt_tdir_in),
        .ckpt_bdir_in   (ckpt_bdir_in),
        .top            (top),
        .bottom         (bottom),
        .tdir           (tdir),
        .bdir           (bdir),
        .empty          (empty),
        .full           (),            // Only needed inside the pointer logic.
        .ckpt_empty     (ckpt_empty),
        .ckpt_full      ()
    );

    ras_write_path ras_write_path_inst (
        .request           (request),
        .op                (op),
        .squash            (squash),
        .squash_op         (squash_op),
        .target            (target),
        .squash_start_addr (squash_start_addr),
        .squash_offset     (squash_offset),
        .squash_rvc        (squash_rvc),
        .top               (top),
        .ckpt_top_in       (ckpt_top_in),
        .empty             (empty),
        .ckpt_empty        (ckpt_empty),
        .we                (we),
        .waddr             (waddr),
        .wdata             (wdata)
    );

    // Newest entry sits one below the top.
    assign raddr = top - 1'b1;

    ras_stack_mem ras_stack_mem_inst (
        .clk   (clk),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (raddr),
        .rdata (rdata)
    );

    assign ret_addr = rdata;
    assign valid    = ~empty;

    // Checkpoint for a later squash.
    assign ckpt_top    = top;
    assign ckpt_bottom = bottom;
    assign ckpt_tdir   = tdir;
    assign ckpt_bdir   = bdir;

endmodule

// File: design/ras_write_path.sv
`timescale 1ns/1ps

module ras_write_path (
    input  logic                         request,
    input  ras_pkg::ras_op_e             op,
    input  logic                         squash,
    input  ras_pkg::ras_op_e             squash_op,
    input  ras_pkg::vaddr_t              target,
    input  ras_pkg::vaddr_t              squash_start_addr,
    input  logic [ras_pkg::OFFSET_W-1:0] squash_offset,
    input  logic                         squash_rvc,
    input  ras_pkg::ptr_t                top,
    input  ras_pkg::ptr_t                ckpt_top_in,
    input  logic                         empty,
    input  logic                         ckpt_empty,
    output logic                         we,
    output ras_pkg::ptr_t                waddr,
    output ras_pkg::vaddr_t              wdata
);
    import ras_pkg::*;

    ras_op_e wr_op;
    ptr_t    base_top;
    logic    base_empty;
    logic    replace;
    vaddr_t  slot_bytes;
    vaddr_t  inst_len;
    vaddr_t  squash_target;

    assign wr_op = squash ? squash_op : op;
    assign we    = (squash | request) & wr_op[1];

    assign base_top   = squash ? ckpt_top_in : top;
    assign base_empty = squash ? ckpt_empty : empty;

    // POP_PUSH rewrites the entry under the top, unless there is none.
    assign replace = (wr_op == POP_PUSH) & ~base_empty;
    assign waddr   = replace ? base_top - 1'b1 : base_top;

    // Return address of the call being replayed.
    assign slot_bytes    = vaddr_t'({squash_offset, {INST_OFFSET{1'b0}}});
    assign inst_len      = squash_rvc ? vaddr_t'(2) : vaddr_t'(4);
    assign squash_target = squash_start_addr + slot_bytes + inst_len;

    assign wdata = squash ? squash_target : target;

endmodule

// File: ras.f
design/ras_pkg.sv
design/ras_ptr_ctrl.sv
design/ras_write_path.sv
design/ras_stack_mem.sv
design/ras_top.sv
sim/tb_ras.sv

// File: sim/tb_ras.sv
`timescale 1ns/1ps

module tb_ras;
    import ras_pkg::*;

    localparam int MAX_CYCLES = 2000;   // Tests need under a hundred cycles.

    logic                clk = 1'b0;
    logic                rst;
    logic                request;
    ras_op_e             op;
    vaddr_t              target;
    logic                squash;
    ras_op_e             squash_op;
    vaddr_t              squash_start_addr;
    logic [OFFSET_W-1:0] squash_offset;
    logic                squash_rvc;
    ptr_t                ckpt_top_in;
    ptr_t                ckpt_bottom_in;
    logic                ckpt_tdir_in;
    logic                ckpt_bdir_in;
    vaddr_t              ret_addr;
    logic                valid;
    ptr_t                ckpt_top;
    ptr_t                ckpt_bottom;
    logic                ckpt_tdir;
    logic                ckpt_bdir;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] lfsr_state = 32'h38b0;

    // Reference stack with pointers that count modulo twice the depth.
    vaddr_t model_mem [RAS_SIZE];
    int     model_top5;
    int     model_bot5;

    // Checkpoint shared by the squash tests.
    ptr_t   saved_top;
    ptr_t   saved_bottom;
    logic   saved_tdir;
    logic   saved_bdir;
    vaddr_t orig [3];

    ras_top ras_top_inst (
        .clk               (clk),
        .rst               (rst),
        .request           (request),
        .op                (op),
        .target            (target),
        .squash            (squash),
        .squash_op         (squash_op),
        .squash_start_addr (squash_start_addr),
        .squash_offset     (squash_offset),
        .squash_rvc        (squash_rvc),
        .ckpt_top_in       (ckpt_top_in),
        .ckpt_bottom_in    (ckpt_bottom_in),
        .ckpt_tdir_in      (ckpt_tdir_in),
        .ckpt_bdir_in      (ckpt_bdir_in),
        .ret_addr          (ret_addr),
        .valid             (valid),
        .ckpt_top          (ckpt_top),
        .ckpt_bottom       (ckpt_bottom),
        .ckpt_tdir         (ckpt_tdir),
        .ckpt_bdir         (ckpt_bdir)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    function automatic vaddr_t squash_return(input vaddr_t start,
                                             input logic [OFFSET_W-1:0] off,
                                             input logic rvc);
        return start + (vaddr_t'(off) << INST_OFFSET) + (rvc ? vaddr_t'(2) : vaddr_t'(4));
    endfunction

    function automatic int stack_depth();
        return (model_top5 - model_bot5 + 2 * RAS_SIZE) % (2 * RAS_SIZE);
    endfunction

    task automatic store_push(input vaddr_t t);
        if (stack_depth() == RAS_SIZE) begin
            model_bot5 = (model_bot5 + 1) % (2 * RAS_SIZE);   // Oldest entry lost.
        end
        model_mem[model_top5 % RAS_SIZE] = t;
        model_top5 = (model_top5 + 1) % (2 * RAS_SIZE);
    endtask

    task automatic apply_to_model(input ras_op_e o, input vaddr_t t);
        case (o)
            PUSH: store_push(t);
            POP: begin
                if (stack_depth() > 0) begin
                    model_top5 = (model_top5 + 2 * RAS_SIZE - 1) % (2 * RAS_SIZE);
                end
            end
            POP_PUSH: begin
                if (stack_depth() == 0) begin
                    store_push(t);
                end else begin
                    model_mem[(model_top5 + 2 * RAS_SIZE - 1) % RAS_SIZE] = t;
                end
            end
            default: ;
        endcase
    endtask

    task automatic restore_model();
        model_top5 = int'(saved_top) + (saved_tdir ? RAS_SIZE : 0);
        model_bot5 = int'(saved_bottom) + (saved_bdir ? RAS_SIZE : 0);
    endtask

    task automatic check_addr(input string name, input vaddr_t got, input vaddr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_ptr(input string name, input ptr_t got, input ptr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_outputs();
        check_flag("valid", valid, stack_depth() != 0);
        check_ptr("ckpt_top", ckpt_top, ptr_t'(model_top5 % RAS_SIZE));
        check_ptr("ckpt_bottom", ckpt_bottom, ptr_t'(model_bot5 % RAS_SIZE));
        check_flag("ckpt_tdir", ckpt_tdir, model_top5 >= RAS_SIZE);
        check_flag("ckpt_bdir", ckpt_bdir, model_bot5 >= RAS_SIZE);
        if (stack_depth() != 0) begin
            check_addr("ret_addr", ret_addr,
                       model_mem[(model_top5 + 2 * RAS_SIZE - 1) % RAS_SIZE]);
        end
    endtask

    // Called 1 ns after an edge and returns 1 ns after the next one.
    task automatic send_request(input ras_op_e o, input vaddr_t t);
        request = 1'b1;
        op      = o;
        target  = t;
        @(posedge clk);
        #1;
        request = 1'b0;
        op      = NONE;
        apply_to_model(o, t);
        check_outputs();
    endtask

    task automatic send_squash(input ras_op_e sop, input vaddr_t start,
                               input logic [OFFSET_W-1:0] off, input logic rvc,
                               input logic with_request);
        squash            = 1'b1;
        squash_op         = sop;
        squash_start_addr = start;
        squash_offset     = off;
        squash_rvc        = rvc;
        ckpt_top_in       = saved_top;
        ckpt_bottom_in    = saved_bottom;
        ckpt_tdir_in      = saved_tdir;
        ckpt_bdir_in      = saved_bdir;
        request           = with_request;   // Must lose to the squash.
        op                = PUSH;
        target            = take_bits(32);
        @(posedge clk);
        #1;
        squash    = 1'b0;
        squash_op = NONE;
        request   = 1'b0;
        op        = NONE;
        restore_model();
        apply_to_model(sop, squash_return(start, off, rvc));
        check_outputs();
    endtask

    task automatic reset_and_lifo();
        vaddr_t pushed [$];
        vaddr_t t;
        check_flag("valid", valid, 1'b0);
        check_ptr("ckpt_top", ckpt_top, '0);
        check_ptr("ckpt_bottom", ckpt_bottom, '0);
        repeat (5) begin
            t = take_bits(32);
            pushed.push_back(t);
            send_request(PUSH, t);
        end
        repeat (5) begin
            check_addr("ret_addr", ret_addr, pushed.pop_back());
            send_request(POP, '0);
        end
        check_flag("valid", valid, 1'b0);
    endtask

    task automatic pop_on_empty();
        ptr_t top_before;
        ptr_t bottom_before;
        top_before    = ckpt_top;
        bottom_before = ckpt_bottom;
        repeat (2) begin
            send_request(POP, '0);
            check_flag("valid", valid, 1'b0);
            check_ptr("ckpt_top", ckpt_top, top_before);
            check_ptr("ckpt_bottom", ckpt_bottom, bottom_before);
        end
    endtask

    task automatic overflow_wrap();
        vaddr_t pushed [$];
        vaddr_t t;
        ptr_t   bottom_before;
        bottom_before = ckpt_bottom;
        repeat (RAS_SIZE + 3) begin
            t = take_bits(32);
            pushed.push_back(t);
            send_request(PUSH, t);
            check_flag("valid", valid, 1'b1);
        end
        check_ptr("ckpt_bottom", ckpt_bottom, ptr_t'(bottom_before + 3));
        check_ptr("ckpt_top", ckpt_top, ptr_t'(bottom_before + 3));
        check_flag("ckpt_tdir ^ ckpt_bdir", ckpt_tdir ^ ckpt_bdir, 1'b1);
        repeat (RAS_SIZE) begin
            check_addr("ret_addr", ret_addr, pushed.pop_back());
            send_request(POP, '0);
        end
        check_flag("valid", valid, 1'b0);
    endtask

    task automatic pop_push_replace();
        vaddr_t p [3];
        vaddr_t t;
        ptr_t   top_before;
        for (int i = 0; i < 3; i++) begin
            p[i] = take_bits(32);
            send_request(PUSH, p[i]);
        end
        top_before = ckpt_top;
        t = take_bits(32);
        send_request(POP_PUSH, t);
        check_addr("ret_addr", ret_addr, t);
        check_ptr("ckpt_top", ckpt_top, top_before);
        send_request(POP, '0);
        check_addr("ret_addr", ret_addr, p[1]);
        send_request(POP, '0);
        send_request(POP, '0);
        check_flag("valid", valid, 1'b0);
    endtask

    task automatic squash_push_replay();
        vaddr_t              start;
        logic [31:0]         bits;
        logic [OFFSET_W-1:0] off;
        logic                rvc;
        vaddr_t              exp_ret;
        for (int i = 0; i < 3; i++) begin
            orig[i] = take_bits(32);
            send_request(PUSH, orig[i]);
        end
        saved_top    = ckpt_top;
        saved_bottom = ckpt_bottom;
        saved_tdir   = ckpt_tdir;
        saved_bdir   = ckpt_bdir;
        for (int r = 0; r < 2; r++) begin
            rvc = (r == 1);
            send_request(PUSH, take_bits(32));   // Wrong path.
            send_request(PUSH, take_bits(32));
            start   = take_bits(32);
            bits    = take_bits(OFFSET_W);
            off     = bits[OFFSET_W-1:0];
            exp_ret = squash_return(start, off, rvc);
            send_squash(PUSH, start, off, rvc, 1'b0);
            check_addr("ret_addr", ret_addr, exp_ret);
            check_ptr("ckpt_top", ckpt_top, ptr_t'(saved_top + 1));
            send_request(POP, '0);
            check_addr("ret_addr", ret_addr, orig[2]);
        end
    endtask

    task automatic squash_pop_priority();
        send_squash(POP, '0, '0, 1'b0, 1'b1);
        check_addr("ret_addr", ret_addr, orig[1]);
        check_ptr("ckpt_top", ckpt_top, ptr_t'(saved_top - 1));
        send_request(POP, '0);
        check_addr("ret_addr", ret_addr, orig[0]);
        send_request(POP, '0);
        check_flag("valid", valid, 1'b0);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst               = 1'b1;
        request           = 1'b0;
        op                = NONE;
        target            = '0;
        squash            = 1'b0;
        squash_op         = NONE;
        squash_start_addr = '0;
        squash_offset     = '0;
        squash_rvc        = 1'b0;
        ckpt_top_in       = '0;
        ckpt_bottom_in    = '0;
        ckpt_tdir_in      = 1'b0;
        ckpt_bdir_in      = 1'b0;
        model_top5        = 0;
        model_bot5        = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_and_lifo();
        pop_on_empty();
        overflow_wrap();
        pop_push_replace();
        squash_push_replay();
        squash_pop_priority();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
